/* src/rab_cfg_config.svh */
// widths, sizes and address map of the RAB configuration block
`ifndef RAB_CFG_CONFIG_SVH
`define RAB_CFG_CONFIG_SVH

// AXI4-Lite port
`define RAB_AXI_DATA_W 64
`define RAB_AXI_ADDR_W 32

// slice contents
`define RAB_VIRT_W   32
`define RAB_PHYS_W   40
`define RAB_N_FLAGS  4
`define RAB_N_REGS   16

// miss handling
`define RAB_META_W   10
`define RAB_MH_DEPTH 16

// address map
`define RAB_CONFIG_SIZE  32'h0000_0020  // config region ends here, L1 starts
`define RAB_L1_END       32'h0000_4000
`define RAB_MH_ADDR_OFS  32'h0000_0000
`define RAB_MH_META_OFS  32'h0000_0008
`define RAB_CONF_OFS     32'h0000_000C

`endif

/* src/rab_cfg_pkg.sv */
// vector types and packed structs shared by the RAB configuration block
`include "rab_cfg_config.svh"

package rab_cfg_pkg;

  typedef logic [`RAB_AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [`RAB_AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [`RAB_AXI_DATA_W/8-1:0] axi_strb_t;

  typedef logic [`RAB_VIRT_W-1:0] virt_addr_t;
  typedef logic [`RAB_META_W-1:0] miss_meta_t;

  // one L1 slice register, always 64 bit wide
  typedef logic [63:0] cfg_word_t;
  typedef logic [$clog2(`RAB_N_REGS)-1:0] reg_idx_t;

  // complete AXI write once both AW and W are in
  typedef struct packed {
    axi_addr_t addr;
    axi_data_t data;
    axi_strb_t strb;
  } wr_cmd_t;

  typedef struct packed {
    virt_addr_t addr;
    miss_meta_t meta;
  } mh_entry_t;

  // bit 1 multi-hit, bit 0 fifo disable
  typedef struct packed {
    logic allow_multi_hit;
    logic fifo_disable;
  } conf_reg_t;

endpackage

/* src/rab_cfg_axi_slave.sv */
// AXI4-Lite slave: channel capture, write pulse generation, B and R sequencing
`timescale 1ns/1ps

module rab_cfg_axi_slave (
  input  logic                  Clk_CI,
  input  logic                  Rst_RBI,
  input  rab_cfg_pkg::axi_addr_t s_axi_awaddr_i,
  input  logic                  s_axi_awvalid_i,
  output logic                  s_axi_awready_o,
  input  rab_cfg_pkg::axi_data_t s_axi_wdata_i,
  input  rab_cfg_pkg::axi_strb_t s_axi_wstrb_i,
  input  logic                  s_axi_wvalid_i,
  output logic                  s_axi_wready_o,
  output logic [1:0]            s_axi_bresp_o,
  output logic                  s_axi_bvalid_o,
  input  logic                  s_axi_bready_i,
  input  rab_cfg_pkg::axi_addr_t s_axi_araddr_i,
  input  logic                  s_axi_arvalid_i,
  output logic                  s_axi_arready_o,
  output rab_cfg_pkg::axi_data_t s_axi_rdata_o,
  output logic [1:0]            s_axi_rresp_o,
  output logic                  s_axi_rvalid_o,
  input  logic                  s_axi_rready_i,
  input  rab_cfg_pkg::axi_data_t rdata_i,
  output rab_cfg_pkg::wr_cmd_t  wr_cmd_o,
  output logic                  wr_en_o,
  output rab_cfg_pkg::axi_addr_t rd_addr_o,
  output logic                  rd_active_o,
  output logic                  rd_done_o
);
  import rab_cfg_pkg::*;

  wr_cmd_t   wr_cmd_q;
  axi_addr_t araddr_q;
  logic      aw_done_q, w_done_q;
  logic      both_done, both_done_dly_q;
  logic      b_done_q, b_run_q;
  logic      ar_done_q, r_done_q, r_run_q;

  assign both_done = aw_done_q & w_done_q;
  assign wr_en_o   = both_done & ~both_done_dly_q;  // one pulse per write

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      s_axi_awready_o <= 1'b1;
      aw_done_q       <= 1'b0;
      s_axi_wready_o  <= 1'b1;
      w_done_q        <= 1'b0;
      both_done_dly_q <= 1'b0;
    end
    else
    begin
      both_done_dly_q <= both_done;
      if (s_axi_awready_o && s_axi_awvalid_i)
      begin
        s_axi_awready_o <= 1'b0;
        aw_done_q       <= 1'b1;
      end
      else if (aw_done_q && b_done_q)
      begin
        s_axi_awready_o <= 1'b1;  // reopen after the response went out
        aw_done_q       <= 1'b0;
      end
      if (s_axi_wready_o && s_axi_wvalid_i)
      begin
        s_axi_wready_o <= 1'b0;
        w_done_q       <= 1'b1;
      end
      else if (w_done_q && b_done_q)
      begin
        s_axi_wready_o <= 1'b1;
        w_done_q       <= 1'b0;
      end
    end
  end

  // captured payloads
  always_ff @(posedge Clk_CI)
  begin
    if (s_axi_awready_o && s_axi_awvalid_i)
      wr_cmd_q.addr <= s_axi_awaddr_i;
    if (s_axi_wready_o && s_axi_wvalid_i)
    begin
      wr_cmd_q.data <= s_axi_wdata_i;
      wr_cmd_q.strb <= s_axi_wstrb_i;
    end
    if (s_axi_arready_o && s_axi_arvalid_i)
      araddr_q <= s_axi_araddr_i;
  end

  // write response
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      s_axi_bvalid_o <= 1'b0;
      b_done_q       <= 1'b0;
      b_run_q        <= 1'b0;
    end
    else if (both_done && !b_done_q)
    begin
      if (!b_run_q)
      begin
        s_axi_bvalid_o <= 1'b1;
        b_run_q        <= 1'b1;
      end
      else if (s_axi_bready_i)
      begin
        s_axi_bvalid_o <= 1'b0;
        b_done_q       <= 1'b1;
        b_run_q        <= 1'b0;
      end
    end
    else
    begin
      s_axi_bvalid_o <= 1'b0;
      b_done_q       <= 1'b0;
      b_run_q        <= 1'b0;
    end
  end

  // read address and read response
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      s_axi_arready_o <= 1'b1;
      ar_done_q       <= 1'b0;
      s_axi_rvalid_o  <= 1'b0;
      r_done_q        <= 1'b0;
      r_run_q         <= 1'b0;
    end
    else
    begin
      if (s_axi_arready_o && s_axi_arvalid_i)
      begin
        s_axi_arready_o <= 1'b0;
        ar_done_q       <= 1'b1;
      end
      else if (ar_done_q && r_done_q)
      begin
        s_axi_arready_o <= 1'b1;
        ar_done_q       <= 1'b0;
      end
      if (ar_done_q && !r_done_q)
      begin
        if (!r_run_q)
        begin
          s_axi_rvalid_o <= 1'b1;
          r_run_q        <= 1'b1;
        end
        else if (s_axi_rready_i)
        begin
          s_axi_rvalid_o <= 1'b0;
          r_done_q       <= 1'b1;
          r_run_q        <= 1'b0;
        end
      end
      else
      begin
        s_axi_rvalid_o <= 1'b0;
        r_done_q       <= 1'b0;
        r_run_q        <= 1'b0;
      end
    end
  end

  assign s_axi_bresp_o = 2'b00;
  assign s_axi_rresp_o = 2'b00;
  assign s_axi_rdata_o = rdata_i;  // selected downstream
  assign wr_cmd_o      = wr_cmd_q;
  assign rd_addr_o     = araddr_q;
  assign rd_active_o   = s_axi_rvalid_o;
  assign rd_done_o     = s_axi_rvalid_o & s_axi_rready_i;

endmodule

/* src/rab_cfg_l1_regs.sv */
// L1 slice register file with per-kind masking and the L1 read word
`timescale 1ns/1ps
`include "rab_cfg_config.svh"

module rab_cfg_l1_regs (
  input  logic                                      Clk_CI,
  input  logic                                      Rst_RBI,
  input  rab_cfg_pkg::wr_cmd_t                      wr_cmd_i,
  input  logic                                      wr_en_i,
  input  rab_cfg_pkg::axi_addr_t                    rd_addr_i,
  output rab_cfg_pkg::cfg_word_t [`RAB_N_REGS-1:0]  l1_cfg_o,
  output rab_cfg_pkg::axi_data_t                    l1_rdata_o
);
  import rab_cfg_pkg::*;

  localparam int IDX_LSB  = 3;  // registers are 64-bit words
  localparam int HALF_BIT = 2;  // upper 32 bits for 32-bit masters
  localparam int HALF_W   = $bits(cfg_word_t) / 2;

  reg_idx_t  wr_idx, rd_idx;
  logic      l1_wr;
  cfg_word_t wr_word, rd_word;

  // valid bits of a register, from index bits 1:0
  function automatic cfg_word_t kind_mask(input logic [1:0] kind);
    cfg_word_t mask;
    if (!kind[1])
      mask = cfg_word_t'({`RAB_VIRT_W{1'b1}});  // virtual address
    else if (!kind[0])
      mask = cfg_word_t'({`RAB_PHYS_W{1'b1}});  // physical address
    else
      mask = cfg_word_t'({`RAB_N_FLAGS{1'b1}}); // flags
    return mask;
  endfunction

  assign wr_idx = wr_cmd_i.addr[IDX_LSB +: $bits(reg_idx_t)];
  assign rd_idx = rd_addr_i[IDX_LSB +: $bits(reg_idx_t)];

  assign l1_wr = wr_en_i && (wr_cmd_i.addr >= `RAB_CONFIG_SIZE) &&
                 (wr_cmd_i.addr < `RAB_L1_END);

  // merge strobed bytes into the old value, then clear what the kind lacks
  always_comb
  begin
    wr_word = l1_cfg_o[wr_idx];
    for (int b = 0; b < $bits(axi_strb_t); b++)
    begin
      if (wr_cmd_i.strb[b])
        wr_word[8*b +: 8] = wr_cmd_i.data[8*b +: 8];
    end
    wr_word = wr_word & kind_mask(wr_idx[1:0]);
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      l1_cfg_o <= '0;
    else if (l1_wr)
      l1_cfg_o[wr_idx] <= wr_word;
  end

  assign rd_word = l1_cfg_o[rd_idx];

  always_comb
  begin
    if (rd_addr_i[HALF_BIT])
      l1_rdata_o = axi_data_t'(rd_word[$bits(cfg_word_t)-1 -: HALF_W]);  // shifted down
    else
      l1_rdata_o = axi_data_t'(rd_word);
  end

endmodule

/* src/rab_cfg_miss_handler.sv */
// configuration register, miss FIFO and final read-data selection
`timescale 1ns/1ps
`include "rab_cfg_config.svh"

module rab_cfg_miss_handler (
  input  logic                    Clk_CI,
  input  logic                    Rst_RBI,
  input  rab_cfg_pkg::wr_cmd_t    wr_cmd_i,
  input  logic                    wr_en_i,
  input  rab_cfg_pkg::axi_addr_t  rd_addr_i,
  input  logic                    rd_active_i,
  input  logic                    rd_done_i,
  input  rab_cfg_pkg::axi_data_t  l1_rdata_i,
  input  logic                    miss_i,
  input  rab_cfg_pkg::virt_addr_t miss_addr_i,
  input  rab_cfg_pkg::miss_meta_t miss_meta_i,
  output rab_cfg_pkg::axi_data_t  rdata_o,
  output logic                    l1_allow_multi_hit_o,
  output logic                    mh_fifo_full_o
);
  import rab_cfg_pkg::*;

  localparam int PTR_W = $clog2(`RAB_MH_DEPTH);
  localparam logic [PTR_W:0] DEPTH = `RAB_MH_DEPTH;

  conf_reg_t         conf_q;
  logic              cfg_wr, hw_push, sw_push, push, push_ok, pop;
  logic              fifo_full, fifo_empty;
  mh_entry_t         push_entry, head;
  mh_entry_t         fifo_mem [`RAB_MH_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]    count_q;

  assign cfg_wr  = wr_en_i && (wr_cmd_i.addr < `RAB_CONFIG_SIZE);
  assign hw_push = miss_i && !conf_q.fifo_disable;
  assign sw_push = cfg_wr && (wr_cmd_i.addr == `RAB_MH_ADDR_OFS) && !conf_q.fifo_disable;
  assign push    = hw_push | sw_push;

  assign fifo_full      = (count_q == DEPTH);
  assign fifo_empty     = (count_q == '0);
  assign push_ok        = push & ~fifo_full;
  assign pop            = rd_done_i && (rd_addr_i == `RAB_MH_META_OFS) && !fifo_empty;
  assign mh_fifo_full_o = push & fifo_full;  // dropped push

  always_comb
  begin
    if (hw_push)
    begin
      push_entry.addr = miss_addr_i;  // hardware miss has priority
      push_entry.meta = miss_meta_i;
    end
    else
    begin
      push_entry.addr = virt_addr_t'(wr_cmd_i.data[`RAB_VIRT_W-1:0]);
      push_entry.meta = '0;
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      conf_q <= '0;
    else if (cfg_wr && (wr_cmd_i.addr == `RAB_CONF_OFS))
      conf_q <= conf_reg_t'(wr_cmd_i.data[$bits(conf_reg_t)-1:0]);
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_ok, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (push_ok)
      fifo_mem[wr_ptr_q] <= push_entry;
  end

  assign head = fifo_empty ? '0 : fifo_mem[rd_ptr_q];

  always_comb
  begin
    rdata_o = l1_rdata_i;
    if (rd_active_i)
    begin
      case (rd_addr_i)
        `RAB_MH_ADDR_OFS:
        begin
          rdata_o = '0;
          rdata_o[`RAB_VIRT_W-1:0] = head.addr;  // peek only
        end
        `RAB_MH_META_OFS:
        begin
          rdata_o = '0;
          rdata_o[31] = fifo_empty;
          rdata_o[`RAB_META_W-1:0] = head.meta;
        end
        `RAB_CONF_OFS:
        begin
          rdata_o = '0;
          rdata_o[$bits(conf_reg_t)-1:0] = conf_q;
        end
        default: rdata_o = l1_rdata_i;
      endcase
    end
  end

  assign l1_allow_multi_hit_o = conf_q.allow_multi_hit;

endmodule

/* src/rab_cfg_top.sv */
// top level: AXI front end, L1 register stage, miss handling and read-out
`timescale 1ns/1ps
`include "rab_cfg_config.svh"

module rab_cfg_top (
  input  logic                                      Clk_CI,
  input  logic                                      Rst_RBI,
  input  rab_cfg_pkg::axi_addr_t                    s_axi_awaddr_i,
  input  logic                                      s_axi_awvalid_i,
  output logic                                      s_axi_awready_o,
  input  rab_cfg_pkg::axi_data_t                    s_axi_wdata_i,
  input  rab_cfg_pkg::axi_strb_t                    s_axi_wstrb_i,
  input  logic                                      s_axi_wvalid_i,
  output logic                                      s_axi_wready_o,
  output logic [1:0]                                s_axi_bresp_o,
  output logic                                      s_axi_bvalid_o,
  input  logic                                      s_axi_bready_i,
  input  rab_cfg_pkg::axi_addr_t                    s_axi_araddr_i,
  input  logic                                      s_axi_arvalid_i,
  output logic                                      s_axi_arready_o,
  output rab_cfg_pkg::axi_data_t                    s_axi_rdata_o,
  output logic [1:0]                                s_axi_rresp_o,
  output logic                                      s_axi_rvalid_o,
  input  logic                                      s_axi_rready_i,
  output rab_cfg_pkg::cfg_word_t [`RAB_N_REGS-1:0]  l1_cfg_o,
  output logic                                      l1_allow_multi_hit_o,
  input  logic                                      miss_i,
  input  rab_cfg_pkg::virt_addr_t                   miss_addr_i,
  input  rab_cfg_pkg::miss_meta_t                   miss_meta_i,
  output logic                                      mh_fifo_full_o
);
  import rab_cfg_pkg::*;

  wr_cmd_t   wr_cmd;
  logic      wr_en;
  axi_addr_t rd_addr;
  logic      rd_active, rd_done;
  axi_data_t l1_rdata, rdata;

  rab_cfg_axi_slave i_axi_slave (
    .Clk_CI          (Clk_CI),
    .Rst_RBI         (Rst_RBI),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .rdata_i         (rdata),
    .wr_cmd_o        (wr_cmd),
    .wr_en_o         (wr_en),
    .rd_addr_o       (rd_addr),
    .rd_active_o     (rd_active),
    .rd_done_o       (rd_done)
  );

  rab_cfg_l1_regs i_l1_regs (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .wr_cmd_i   (wr_cmd),
    .wr_en_i    (wr_en),
    .rd_addr_i  (rd_addr),
    .l1_cfg_o   (l1_cfg_o),
    .l1_rdata_o (l1_rdata)
  );

  rab_cfg_miss_handler i_miss_handler (
    .Clk_CI               (Clk_CI),
    .Rst_RBI              (Rst_RBI),
    .wr_cmd_i             (wr_cmd),
    .wr_en_i              (wr_en),
    .rd_addr_i            (rd_addr),
    .rd_active_i          (rd_active),
    .rd_done_i            (rd_done),
    .l1_rdata_i           (l1_rdata),
    .miss_i               (miss_i),
    .miss_addr_i          (miss_addr_i),
    .miss_meta_i          (miss_meta_i),
    .rdata_o              (rdata),
    .l1_allow_multi_hit_o (l1_allow_multi_hit_o),
    .mh_fifo_full_o       (mh_fifo_full_o)
  );

endmodule

/* tests/rab_cfg_clk_gen.sv */
// clock and reset generator for the RAB configuration testbench
`timescale 1ns/1ps

module rab_cfg_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #(PERIOD_NS / 8) rst_n_o = 1'b1;  // released away from both clock edges
  end

endmodule

/* tests/rab_cfg_assert.sv */
// AXI4-Lite response assertions, bound into the slave of the RAB configuration block
`timescale 1ns/1ps

module rab_cfg_assert (
  input logic                   Clk_CI,
  input logic                   Rst_RBI,
  input logic                   awready_i,
  input logic                   bvalid_i,
  input logic                   bready_i,
  input logic                   rvalid_i,
  input logic                   rready_i,
  input rab_cfg_pkg::axi_data_t rdata_i
);

  int unsigned fail_count;  // failed assertions so far

  initial fail_count = 0;

  bvalid_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_i && !bready_i |=> bvalid_i)
  else
  begin
    fail_count = fail_count + 1;
    $error("bvalid dropped before bready");
  end

  // read data must not move while the master stalls
  rvalid_stable: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
  else
  begin
    fail_count = fail_count + 1;
    $error("rvalid or rdata changed before rready");
  end

  no_aw_during_b: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_i |-> !awready_i)
  else
  begin
    fail_count = fail_count + 1;
    $error("awready high while a write response is pending");
  end

endmodule

bind rab_cfg_axi_slave rab_cfg_assert i_axi_assert (
  .Clk_CI    (Clk_CI),
  .Rst_RBI   (Rst_RBI),
  .awready_i (s_axi_awready_o),
  .bvalid_i  (s_axi_bvalid_o),
  .bready_i  (s_axi_bready_i),
  .rvalid_i  (s_axi_rvalid_o),
  .rready_i  (s_axi_rready_i),
  .rdata_i   (s_axi_rdata_o)
);

/* tests/rab_cfg_tb.sv */
// directed testbench for the RAB configuration block: AXI tasks, compare tasks, tests
`timescale 1ns/1ps
`include "rab_cfg_config.svh"

module rab_cfg_tb;
  import rab_cfg_pkg::*;

  localparam int TIMEOUT_CYC = 200;

  logic       Clk_CI, Rst_RBI;
  axi_addr_t  awaddr, araddr;
  axi_data_t  wdata, rdata;
  axi_strb_t  wstrb;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;
  logic       multi_hit, miss, fifo_full;
  virt_addr_t miss_addr;
  miss_meta_t miss_meta;
  cfg_word_t [`RAB_N_REGS-1:0] l1_cfg;
  cfg_word_t  shadow [`RAB_N_REGS];  // expected L1 contents
  integer     seed;

  rab_cfg_clk_gen i_clk_gen (
    .clk_o   (Clk_CI),
    .rst_n_o (Rst_RBI)
  );

  rab_cfg_top i_dut (
    .Clk_CI               (Clk_CI),
    .Rst_RBI              (Rst_RBI),
    .s_axi_awaddr_i       (awaddr),
    .s_axi_awvalid_i      (awvalid),
    .s_axi_awready_o      (awready),
    .s_axi_wdata_i        (wdata),
    .s_axi_wstrb_i        (wstrb),
    .s_axi_wvalid_i       (wvalid),
    .s_axi_wready_o       (wready),
    .s_axi_bresp_o        (bresp),
    .s_axi_bvalid_o       (bvalid),
    .s_axi_bready_i       (bready),
    .s_axi_araddr_i       (araddr),
    .s_axi_arvalid_i      (arvalid),
    .s_axi_arready_o      (arready),
    .s_axi_rdata_o        (rdata),
    .s_axi_rresp_o        (rresp),
    .s_axi_rvalid_o       (rvalid),
    .s_axi_rready_i       (rready),
    .l1_cfg_o             (l1_cfg),
    .l1_allow_multi_hit_o (multi_hit),
    .miss_i               (miss),
    .miss_addr_i          (miss_addr),
    .miss_meta_i          (miss_meta),
    .mh_fifo_full_o       (fifo_full)
  );

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // a failed protocol assertion ends the run right away
  always @(posedge Clk_CI)
  begin
    if (i_dut.i_axi_slave.i_axi_assert.fail_count != 0)
      stop_on_error();
  end

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    stop_on_error();
  endtask

  task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_cfg(input string name, input cfg_word_t got, input cfg_word_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  // register value after a strobed write cut to the width of its kind
  function automatic cfg_word_t expect_reg(input cfg_word_t old, input axi_data_t data,
                                           input axi_strb_t strb, input int idx);
    cfg_word_t w;
    int        width;
    for (int b = 0; b < 8; b++)
      w[8*b +: 8] = strb[b] ? data[8*b +: 8] : old[8*b +: 8];
    case (idx % 4)
      0, 1:    width = `RAB_VIRT_W;
      2:       width = `RAB_PHYS_W;
      default: width = `RAB_N_FLAGS;
    endcase
    for (int i = width; i < 64; i++)
      w[i] = 1'b0;
    return w;
  endfunction

  function automatic axi_addr_t l1_addr(input int idx);
    return axi_addr_t'(idx * 8);
  endfunction

  function automatic axi_data_t rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
    int   cnt;
    logic aw_hs, w_hs;
    @(negedge Clk_CI);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    cnt     = 0;
    while (awvalid || wvalid)
    begin
      aw_hs = awvalid & awready;  // handshake at the coming rising edge
      w_hs  = wvalid & wready;
      @(negedge Clk_CI);
      if (aw_hs)
        awvalid = 1'b0;
      if (w_hs)
        wvalid = 1'b0;
      cnt++;
      if (cnt > TIMEOUT_CYC)
        report_timeout("awready/wready");
    end
    cnt = 0;
    while (!bvalid)
    begin
      @(negedge Clk_CI);
      cnt++;
      if (cnt > TIMEOUT_CYC)
        report_timeout("bvalid");
    end
    check_resp("s_axi_bresp_o", bresp, 2'b00);
    @(negedge Clk_CI);  // one cycle of back-pressure
    bready = 1'b1;
    @(negedge Clk_CI);
    bready = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
    int cnt;
    @(negedge Clk_CI);
    araddr  = addr;
    arvalid = 1'b1;
    cnt     = 0;
    while (!arready)
    begin
      @(negedge Clk_CI);
      cnt++;
      if (cnt > TIMEOUT_CYC)
        report_timeout("arready");
    end
    @(negedge Clk_CI);
    arvalid = 1'b0;
    cnt     = 0;
    while (!rvalid)
    begin
      @(negedge Clk_CI);
      cnt++;
      if (cnt > TIMEOUT_CYC)
        report_timeout("rvalid");
    end
    @(negedge Clk_CI);
    rready = 1'b1;
    data   = rdata;
    check_resp("s_axi_rresp_o", rresp, 2'b00);
    @(negedge Clk_CI);
    rready = 1'b0;
  endtask

  task automatic push_miss(input virt_addr_t addr, input miss_meta_t meta, input logic exp_full);
    @(negedge Clk_CI);
    miss      = 1'b1;
    miss_addr = addr;
    miss_meta = meta;
    #1;
    check_bit("mh_fifo_full_o", fifo_full, exp_full);
    @(negedge Clk_CI);
    miss = 1'b0;
  endtask

  task automatic write_l1(input int idx, input axi_data_t data, input axi_strb_t strb);
    cfg_word_t exp;
    exp = expect_reg(shadow[idx], data, strb, idx);
    axi_write(l1_addr(idx), data, strb);
    shadow[idx] = exp;
    check_cfg($sformatf("l1_cfg_o[%0d]", idx), l1_cfg[idx], exp);
  endtask

  task automatic read_l1(input int idx);
    axi_data_t v;
    axi_read(l1_addr(idx), v);
    check_data("s_axi_rdata_o", v, shadow[idx]);
    axi_read(l1_addr(idx) + 4, v);  // upper half
    check_data("s_axi_rdata_o", v, {32'h0, shadow[idx][63:32]});
  endtask

  task automatic test_reset();
    check_bit("s_axi_awready_o", awready, 1'b1);
    check_bit("s_axi_wready_o", wready, 1'b1);
    check_bit("s_axi_arready_o", arready, 1'b1);
    check_bit("s_axi_bvalid_o", bvalid, 1'b0);
    check_bit("s_axi_rvalid_o", rvalid, 1'b0);
    for (int i = 0; i < `RAB_N_REGS; i++)
      check_cfg($sformatf("l1_cfg_o[%0d]", i), l1_cfg[i], '0);
    check_bit("l1_allow_multi_hit_o", multi_hit, 1'b0);
    check_bit("mh_fifo_full_o", fifo_full, 1'b0);
  endtask

  task automatic test_l1_masking();
    write_l1(4, rand_data(), 8'hFF);
    read_l1(4);
    write_l1(6, rand_data(), 8'hFF);
    read_l1(6);
    write_l1(7, rand_data(), 8'hFF);
    read_l1(7);
  endtask

  task automatic test_partial_strobe();
    write_l1(5, rand_data(), 8'hFF);
    write_l1(5, rand_data(), 8'h0F);
    read_l1(5);
    write_l1(5, rand_data(), 8'h06);  // bytes 0 and 3 must survive
    read_l1(5);
  endtask

  task automatic test_config();
    axi_data_t v;
    axi_write(`RAB_CONF_OFS, 64'h2, 8'hFF);
    check_bit("l1_allow_multi_hit_o", multi_hit, 1'b1);
    axi_read(`RAB_CONF_OFS, v);
    check_data("s_axi_rdata_o", v, 64'h2);
  endtask

  task automatic test_miss_fifo();
    virt_addr_t exp_addr [`RAB_MH_DEPTH];
    miss_meta_t exp_meta [`RAB_MH_DEPTH];
    axi_data_t  v;
    for (int i = 0; i < 3; i++)
    begin
      exp_addr[i] = $random(seed);
      exp_meta[i] = miss_meta_t'($random(seed));
      push_miss(exp_addr[i], exp_meta[i], 1'b0);
    end
    for (int i = 0; i < 3; i++)
    begin
      axi_read(`RAB_MH_ADDR_OFS, v);
      check_data("s_axi_rdata_o", v, {32'h0, exp_addr[i]});
      axi_read(`RAB_MH_META_OFS, v);
      check_data("s_axi_rdata_o", v, axi_data_t'(exp_meta[i]));
    end
    axi_read(`RAB_MH_META_OFS, v);
    check_data("s_axi_rdata_o", v, 64'h8000_0000);
    // fill to the brim and then push one too many
    for (int i = 0; i <= `RAB_MH_DEPTH; i++)
    begin
      if (i < `RAB_MH_DEPTH)
      begin
        exp_addr[i] = $random(seed);
        exp_meta[i] = miss_meta_t'($random(seed));
        push_miss(exp_addr[i], exp_meta[i], 1'b0);
      end
      else
        push_miss($random(seed), miss_meta_t'($random(seed)), 1'b1);
    end
    for (int i = 0; i < `RAB_MH_DEPTH; i++)
    begin
      axi_read(`RAB_MH_ADDR_OFS, v);
      check_data("s_axi_rdata_o", v, {32'h0, exp_addr[i]});
      axi_read(`RAB_MH_META_OFS, v);
      check_data("s_axi_rdata_o", v, axi_data_t'(exp_meta[i]));
    end
    axi_read(`RAB_MH_META_OFS, v);
    check_data("s_axi_rdata_o", v, 64'h8000_0000);
  endtask

  task automatic test_fifo_disable();
    axi_data_t v, d;
    axi_write(`RAB_CONF_OFS, 64'h1, 8'hFF);
    check_bit("l1_allow_multi_hit_o", multi_hit, 1'b0);
    push_miss($random(seed), miss_meta_t'($random(seed)), 1'b0);
    axi_read(`RAB_MH_META_OFS, v);
    check_data("s_axi_rdata_o", v, 64'h8000_0000);  // miss was ignored
    axi_write(`RAB_CONF_OFS, 64'h0, 8'hFF);
    d = rand_data();
    axi_write(`RAB_MH_ADDR_OFS, d, 8'hFF);
    axi_read(`RAB_MH_ADDR_OFS, v);
    check_data("s_axi_rdata_o", v, {32'h0, d[31:0]});
    axi_read(`RAB_MH_META_OFS, v);
    check_data("s_axi_rdata_o", v, 64'h0);
    axi_read(`RAB_MH_META_OFS, v);
    check_data("s_axi_rdata_o", v, 64'h8000_0000);
  endtask

  initial
  begin
    int cnt;
    seed      = 32'h2ede0fee;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    miss      = 1'b0;
    miss_addr = '0;
    miss_meta = '0;
    for (int i = 0; i < `RAB_N_REGS; i++)
      shadow[i] = '0;
    cnt = 0;
    while (Rst_RBI !== 1'b1)
    begin
      @(negedge Clk_CI);
      cnt++;
      if (cnt > TIMEOUT_CYC)
        report_timeout("reset release");
    end
    test_reset();
    test_l1_masking();
    test_partial_strobe();
    test_config();
    test_miss_fifo();
    test_fifo_disable();
    @(negedge Clk_CI);
    if (i_dut.i_axi_slave.i_axi_assert.fail_count == 0)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
    begin
      $display("TEST FAILED");
      $fatal(1, "AXI protocol assertion failed");
    end
  end

endmodule

/* project.f */
+incdir+src
src/rab_cfg_pkg.sv
src/rab_cfg_axi_slave.sv
src/rab_cfg_l1_regs.sv
src/rab_cfg_miss_handler.sv
src/rab_cfg_top.sv
tests/rab_cfg_clk_gen.sv
tests/rab_cfg_assert.sv
tests/rab_cfg_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator and run; succeeds only if the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module rab_cfg_tb -o rab_cfg_sim &&
./obj_dir/rab_cfg_sim +verilator+error+limit+100 | tee /dev/stderr \
  | grep -x "TEST PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
